// ==== common/ntm_pkg.sv ====
// Shared constants and types for the matrix inverter peripheral
// The matrix RAM has a fixed pitch of 8 columns, so the largest matrix is 8 by 8
// The state enums carry a prefix because both FSMs share this package

package ntm_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Row pitch of the matrix RAM
  localparam int MAX_COLS  = 8;
  localparam int RAM_DEPTH = 64;
  // Word address width into the RAM
  localparam int ADDR_SIZE = $clog2(RAM_DEPTH);

  //////////////////////////////
  // APB map
  //////////////////////////////

  typedef enum logic [11:0] {
    REG_CTRL   = 12'h000,
    REG_STATUS = 12'h004,
    REG_MODULO = 12'h008,
    REG_SIZE_I = 12'h00C,
    REG_SIZE_J = 12'h010
  } apb_reg_e;

  // Matrix window, element k at base plus 4k
  localparam logic [11:0] WINDOW_BASE = 12'h100;

  //////////////////////////////
  // FSM states
  //////////////////////////////

  typedef enum logic [2:0] {
    ENG_IDLE, ENG_READ, ENG_WAIT_DATA, ENG_INVERT, ENG_WRITE, ENG_NEXT
  } engine_state_e;

  typedef enum logic [1:0] {
    EU_IDLE, EU_REDUCE, EU_FINISH
  } euclid_state_e;

endpackage

// ==== common/ntm_mem_if.sv ====
// One requester's port onto the shared matrix RAM
// The requester holds req, we, addr and wdata steady until gnt
// gnt comes back in the same cycle as req, rdata one cycle after the grant

interface ntm_mem_if #(
  parameter int DATA_SIZE = 16,
  parameter int ADDR_SIZE = ntm_pkg::ADDR_SIZE
);

  // Request side
  logic                 req;
  logic                 we;
  logic [ADDR_SIZE-1:0] addr;
  logic [DATA_SIZE-1:0] wdata;

  // Arbiter side
  logic                 gnt;
  logic [DATA_SIZE-1:0] rdata;

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

// ==== verilog/ntm_matrix_ram.sv ====
// Single-port matrix RAM, 64 words, synchronous read
// Read data is valid one cycle after en
// Contents are undefined until written

module ntm_matrix_ram #(
  parameter int DATA_SIZE = 16
) (
  input  logic                          CLK,
  input  logic                          en,
  input  logic                          we,
  input  logic [ntm_pkg::ADDR_SIZE-1:0] addr,
  input  logic [DATA_SIZE-1:0]          wdata,
  output logic [DATA_SIZE-1:0]          rdata
);

  logic [DATA_SIZE-1:0] mem [ntm_pkg::RAM_DEPTH];

  // Read before write on the same address
  always_ff @(posedge CLK) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];
    end
  end

endmodule

// ==== verilog/ntm_mem_arbiter.sv ====
// Round-robin arbiter for two requesters onto the single-port RAM
// Grants are combinational, at most one per cycle
// Read data goes only to the requester of the last read

module ntm_mem_arbiter #(
  parameter int DATA_SIZE = 16
) (
  input  logic                          CLK,
  input  logic                          RST,
  ntm_mem_if.arbiter                    host,
  ntm_mem_if.arbiter                    engine,
  output logic                          ram_en,
  output logic                          ram_we,
  output logic [ntm_pkg::ADDR_SIZE-1:0] ram_addr,
  output logic [DATA_SIZE-1:0]          ram_wdata,
  input  logic [DATA_SIZE-1:0]          ram_rdata
);

  // High when the engine held the last grant
  logic last_engine;
  // High when the last read was the engine's
  logic rd_engine;

  // Tie goes to whoever was not granted last
  assign host.gnt   = host.req && (!engine.req || last_engine);
  assign engine.gnt = engine.req && !host.gnt;

  //////////////////////////////
  // RAM mux
  //////////////////////////////

  assign ram_en    = host.gnt || engine.gnt;
  assign ram_we    = host.gnt ? host.we : (engine.gnt && engine.we);
  assign ram_addr  = host.gnt ? host.addr : engine.addr;
  assign ram_wdata = host.gnt ? host.wdata : engine.wdata;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      last_engine <= 1'b0;
      rd_engine   <= 1'b0;
    end else if (ram_en) begin
      last_engine <= engine.gnt;
      // Writes leave the read owner alone
      if (!ram_we) begin
        rd_engine <= engine.gnt;
      end
    end
  end

  // Read return routing
  assign host.rdata   = rd_engine ? '0 : ram_rdata;
  assign engine.rdata = rd_engine ? ram_rdata : '0;

  // A requester left waiting wins the next cycle if it still asks
  assert property (@(posedge CLK) disable iff (RST)
                   (host.req && !host.gnt) |=> (!host.req || host.gnt));
  assert property (@(posedge CLK) disable iff (RST)
                   (engine.req && !engine.gnt) |=> (!engine.req || engine.gnt));

endmodule

// ==== verilog/ntm_apb_regs.sv ====
// APB slave for configuration, status and the matrix data window
// Register accesses finish in the first access cycle
// Window accesses stall through pready until the RAM arbiter grants them
// Configuration writes, starts and window accesses are refused while busy

module ntm_apb_regs #(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  // APB
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [11:0]          paddr,
  input  logic [DATA_SIZE-1:0] pwdata,
  output logic [DATA_SIZE-1:0] prdata,
  output logic                 pready,
  output logic                 pslverr,
  // RAM requester
  ntm_mem_if.requester         mem,
  // Engine
  output logic                 start,
  output logic [DATA_SIZE-1:0] modulo,
  output logic [DATA_SIZE-1:0] size_i,
  output logic [DATA_SIZE-1:0] size_j,
  input  logic                 busy,
  input  logic                 finish,
  input  logic                 no_inverse,
  output logic                 done
);

  //////////////////////////////
  // Decode
  //////////////////////////////

  logic access;
  logic is_window;
  logic cfg_write;
  logic ctrl_start;
  logic start_ok;
  logic rd_pending;
  logic no_inv_q;

  assign access    = psel && penable;
  assign is_window = (paddr[11:8] == ntm_pkg::WINDOW_BASE[11:8]);
  assign cfg_write = access && pwrite && !is_window &&
                     (paddr == ntm_pkg::REG_MODULO || paddr == ntm_pkg::REG_SIZE_I ||
                      paddr == ntm_pkg::REG_SIZE_J);
  assign ctrl_start = access && pwrite && !is_window && paddr == ntm_pkg::REG_CTRL && pwdata[0];

  // Odd modulus of at least 3 and sizes 1 to 8
  assign start_ok = modulo[0] && (modulo >= 3) &&
                    (size_i != 0) && (size_i <= ntm_pkg::MAX_COLS) &&
                    (size_j != 0) && (size_j <= ntm_pkg::MAX_COLS);

  // One-cycle pulse since a register access lasts one cycle
  assign start = ctrl_start && !busy && start_ok;

  assign pslverr = (cfg_write && busy) || (ctrl_start && (busy || !start_ok)) ||
                   (access && is_window && busy);

  // Refused window accesses finish at once
  assign pready = access && (!is_window || busy || (pwrite ? mem.gnt : rd_pending));

  //////////////////////////////
  // Window requests
  //////////////////////////////

  assign mem.req   = access && is_window && !busy && !rd_pending;
  assign mem.we    = pwrite;
  assign mem.addr  = paddr[7:2];
  assign mem.wdata = pwdata;

  // RAM data shows up the cycle after a read grant
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= mem.gnt && !mem.we;
    end
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      modulo   <= '0;
      size_i   <= '0;
      size_j   <= '0;
      done     <= 1'b0;
      no_inv_q <= 1'b0;
    end else begin
      if (cfg_write && !busy) begin
        case (paddr)
          ntm_pkg::REG_MODULO: modulo <= pwdata;
          ntm_pkg::REG_SIZE_I: size_i <= pwdata;
          default:             size_j <= pwdata;
        endcase
      end
      // Sticky flags cleared by the next accepted start
      if (start) begin
        done     <= 1'b0;
        no_inv_q <= 1'b0;
      end else if (finish) begin
        done     <= 1'b1;
        no_inv_q <= no_inverse;
      end
    end
  end

  // Read mux where CTRL reads as zero
  always_comb begin
    prdata = '0;
    if (is_window) begin
      prdata = mem.rdata;
    end else begin
      case (paddr)
        ntm_pkg::REG_STATUS: prdata[2:0] = {no_inv_q, done, busy};
        ntm_pkg::REG_MODULO: prdata = modulo;
        ntm_pkg::REG_SIZE_I: prdata = size_i;
        ntm_pkg::REG_SIZE_J: prdata = size_j;
        default:             prdata = '0;
      endcase
    end
  end

  // A granted window read completes one cycle later
  assert property (@(posedge CLK) disable iff (RST) (mem.gnt && !mem.we) |=> pready);

endmodule

// ==== matrix_inverter/ntm_scalar_inverter.sv ====
// Binary extended Euclid modular inverter
// Needs an odd modulus of at least 3
// Latency 2 up to about 2*DATA_SIZE+2 cycles, done pulses once at the end
// No inverse gives result 0 with no_inverse set

module ntm_scalar_inverter #(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  logic [DATA_SIZE-1:0] operand,
  input  logic [DATA_SIZE-1:0] modulo,
  output logic                 done,
  output logic [DATA_SIZE-1:0] result,
  output logic                 no_inverse
);

  ntm_pkg::euclid_state_e state_q;

  // Invariants u = x1*a and v = x2*a, mod m
  logic [DATA_SIZE-1:0] u_q;
  logic [DATA_SIZE-1:0] v_q;
  logic [DATA_SIZE-1:0] x1_q;
  logic [DATA_SIZE-1:0] x2_q;
  logic [DATA_SIZE-1:0] mod_q;
  logic                 terminal;

  // x/2 mod m, m odd
  function automatic logic [DATA_SIZE-1:0] mod_half(input logic [DATA_SIZE-1:0] x,
                                                    input logic [DATA_SIZE-1:0] m);
    logic [DATA_SIZE:0] sum;
    sum = x[0] ? ({1'b0, x} + {1'b0, m}) : {1'b0, x};
    return sum[DATA_SIZE:1];
  endfunction

  // a-b mod m, both already below m
  function automatic logic [DATA_SIZE-1:0] mod_sub(input logic [DATA_SIZE-1:0] a,
                                                   input logic [DATA_SIZE-1:0] b,
                                                   input logic [DATA_SIZE-1:0] m);
    logic [DATA_SIZE:0] diff;
    diff = (a >= b) ? ({1'b0, a} - {1'b0, b}) : ({1'b0, a} + {1'b0, m} - {1'b0, b});
    return diff[DATA_SIZE-1:0];
  endfunction

  // u hits 0 only when the gcd is above 1
  assign terminal = (u_q == 1) || (v_q == 1) || (u_q == 0);
  assign done     = (state_q == ntm_pkg::EU_FINISH);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q    <= ntm_pkg::EU_IDLE;
      no_inverse <= 1'b0;
    end else begin
      case (state_q)
        ntm_pkg::EU_IDLE: if (start) state_q <= ntm_pkg::EU_REDUCE;
        ntm_pkg::EU_REDUCE: begin
          if (terminal) begin
            no_inverse <= (u_q == 0);
            state_q    <= ntm_pkg::EU_FINISH;
          end
        end
        default: state_q <= ntm_pkg::EU_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (state_q == ntm_pkg::EU_IDLE && start) begin
      // Reduce first, then v starts at m
      u_q   <= operand % modulo;
      v_q   <= modulo;
      x1_q  <= 1;
      x2_q  <= '0;
      mod_q <= modulo;
    end else if (state_q == ntm_pkg::EU_REDUCE) begin
      if (u_q == 1) begin
        result <= x1_q;
      end else if (v_q == 1) begin
        result <= x2_q;
      end else if (u_q == 0) begin
        result <= '0;
      end else if (!u_q[0]) begin
        u_q  <= u_q >> 1;
        x1_q <= mod_half(x1_q, mod_q);
      end else if (!v_q[0]) begin
        v_q  <= v_q >> 1;
        x2_q <= mod_half(x2_q, mod_q);
      end else if (u_q >= v_q) begin
        // Both odd, difference is even so halve it in the same step
        u_q  <= (u_q - v_q) >> 1;
        x1_q <= mod_half(mod_sub(x1_q, x2_q, mod_q), mod_q);
      end else begin
        v_q  <= (v_q - u_q) >> 1;
        x2_q <= mod_half(mod_sub(x2_q, x1_q, mod_q), mod_q);
      end
    end
  end

  // Even moduli are refused by the register block
  assert property (@(posedge CLK) disable iff (RST) start |-> modulo[0]);

endmodule

// ==== matrix_inverter/ntm_matrix_inverter.sv ====
// Walks the matrix row by row and inverts each element in place
// Modulus and sizes must stay stable while busy
// Sizes are assumed to be 1 to 8, checked before start

module ntm_matrix_inverter #(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  logic [DATA_SIZE-1:0] modulo,
  input  logic [DATA_SIZE-1:0] size_i,
  input  logic [DATA_SIZE-1:0] size_j,
  output logic                 busy,
  output logic                 finish,
  output logic                 no_inverse,
  ntm_mem_if.requester         mem
);

  ntm_pkg::engine_state_e state_q;

  // Element indices
  logic [3:0] row_q;
  logic [3:0] col_q;
  logic       row_last;
  logic       col_last;

  // Scalar inverter
  logic                 inv_start;
  logic                 inv_done;
  logic                 inv_no_inv;
  logic [DATA_SIZE-1:0] inv_result;
  logic [DATA_SIZE-1:0] result_q;

  assign row_last = (row_q + 4'd1) == size_i;
  assign col_last = (col_q + 4'd1) == size_j;

  //////////////////////////////
  // RAM requests
  //////////////////////////////

  assign mem.req   = (state_q == ntm_pkg::ENG_READ) || (state_q == ntm_pkg::ENG_WRITE);
  assign mem.we    = (state_q == ntm_pkg::ENG_WRITE);
  // Fixed pitch of 8, address is row*8 + col
  assign mem.addr  = {row_q[2:0], col_q[2:0]};
  assign mem.wdata = result_q;

  assign inv_start = (state_q == ntm_pkg::ENG_WAIT_DATA);
  assign busy      = (state_q != ntm_pkg::ENG_IDLE);
  assign finish    = (state_q == ntm_pkg::ENG_NEXT) && row_last && col_last;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q    <= ntm_pkg::ENG_IDLE;
      row_q      <= '0;
      col_q      <= '0;
      no_inverse <= 1'b0;
    end else begin
      case (state_q)
        ntm_pkg::ENG_IDLE: begin
          if (start) begin
            row_q      <= '0;
            col_q      <= '0;
            no_inverse <= 1'b0;
            state_q    <= ntm_pkg::ENG_READ;
          end
        end
        ntm_pkg::ENG_READ: begin
          if (mem.gnt) state_q <= ntm_pkg::ENG_WAIT_DATA;
        end
        // RAM data valid here, fed straight to the inverter
        ntm_pkg::ENG_WAIT_DATA: state_q <= ntm_pkg::ENG_INVERT;
        ntm_pkg::ENG_INVERT: begin
          if (inv_done) begin
            no_inverse <= no_inverse | inv_no_inv;
            state_q    <= ntm_pkg::ENG_WRITE;
          end
        end
        ntm_pkg::ENG_WRITE: begin
          if (mem.gnt) state_q <= ntm_pkg::ENG_NEXT;
        end
        default: begin
          // Column wraps at size_j, then the row advances
          if (row_last && col_last) begin
            state_q <= ntm_pkg::ENG_IDLE;
          end else begin
            if (col_last) begin
              col_q <= '0;
              row_q <= row_q + 4'd1;
            end else begin
              col_q <= col_q + 4'd1;
            end
            state_q <= ntm_pkg::ENG_READ;
          end
        end
      endcase
    end
  end

  // Write-back value
  always_ff @(posedge CLK) begin
    if (state_q == ntm_pkg::ENG_INVERT && inv_done) result_q <= inv_result;
  end

  ntm_scalar_inverter #(.DATA_SIZE(DATA_SIZE)) scalar_inverter (
    .CLK(CLK), .RST(RST),
    .start(inv_start), .operand(mem.rdata), .modulo(modulo),
    .done(inv_done), .result(inv_result), .no_inverse(inv_no_inv)
  );

  assert property (@(posedge CLK) disable iff (RST) busy |-> (col_q < ntm_pkg::MAX_COLS));

endmodule

// ==== verilog/ntm_inverter_top.sv ====
// Matrix modular inverter peripheral, APB slave on plain ports
// paddr is 12 bits, registers below 0x100, matrix window from 0x100
// done follows the STATUS done bit

module ntm_inverter_top #(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [11:0]          paddr,
  input  logic [DATA_SIZE-1:0] pwdata,
  output logic [DATA_SIZE-1:0] prdata,
  output logic                 pready,
  output logic                 pslverr,
  output logic                 done
);

  // Engine control
  logic                 start;
  logic                 busy;
  logic                 finish;
  logic                 no_inverse;
  logic [DATA_SIZE-1:0] modulo;
  logic [DATA_SIZE-1:0] size_i;
  logic [DATA_SIZE-1:0] size_j;

  // RAM port
  logic                          ram_en;
  logic                          ram_we;
  logic [ntm_pkg::ADDR_SIZE-1:0] ram_addr;
  logic [DATA_SIZE-1:0]          ram_wdata;
  logic [DATA_SIZE-1:0]          ram_rdata;

  ntm_mem_if #(.DATA_SIZE(DATA_SIZE), .ADDR_SIZE(ntm_pkg::ADDR_SIZE)) host_mem ();
  ntm_mem_if #(.DATA_SIZE(DATA_SIZE), .ADDR_SIZE(ntm_pkg::ADDR_SIZE)) engine_mem ();

  ntm_apb_regs #(.DATA_SIZE(DATA_SIZE)) apb_regs (
    .CLK(CLK), .RST(RST),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .mem(host_mem.requester),
    .start(start), .modulo(modulo), .size_i(size_i), .size_j(size_j),
    .busy(busy), .finish(finish), .no_inverse(no_inverse), .done(done)
  );

  ntm_matrix_inverter #(.DATA_SIZE(DATA_SIZE)) matrix_inverter (
    .CLK(CLK), .RST(RST),
    .start(start), .modulo(modulo), .size_i(size_i), .size_j(size_j),
    .busy(busy), .finish(finish), .no_inverse(no_inverse),
    .mem(engine_mem.requester)
  );

  ntm_mem_arbiter #(.DATA_SIZE(DATA_SIZE)) mem_arbiter (
    .CLK(CLK), .RST(RST),
    .host(host_mem.arbiter), .engine(engine_mem.arbiter),
    .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
    .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
  );

  ntm_matrix_ram #(.DATA_SIZE(DATA_SIZE)) matrix_ram (
    .CLK(CLK), .en(ram_en), .we(ram_we), .addr(ram_addr),
    .wdata(ram_wdata), .rdata(ram_rdata)
  );

endmodule

// ==== dv/ntm_inverter_tb.sv ====
// Testbench for the matrix modular inverter peripheral
// Runs from the project root and reads dv/inverter_stim.txt
// Each stim case is the hex tokens modulus size_i size_j no_inverse start_err
// followed by the elements row by row and as many expected results
// A refused start carries no elements and no results
// Stops at the first error

module ntm_inverter_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DATA_SIZE   = 16;
  // Worst inverter latency plus RAM and APB traffic per element
  localparam int ELEM_CYCLES = 2 * DATA_SIZE + 10;

  logic                 CLK;
  logic                 RST;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [11:0]          paddr;
  logic [DATA_SIZE-1:0] pwdata;
  logic [DATA_SIZE-1:0] prdata;
  logic                 pready;
  logic                 pslverr;
  logic                 done;

  // Cases from the stim file with all elements back to back
  int case_mod[$];
  int case_size_i[$];
  int case_size_j[$];
  int case_no_inv[$];
  int case_err[$];
  int elem_q[$];
  int expect_q[$];
  int elem_base = 0;

  logic [31:0] lfsr_q      = 32'h76e8;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic        done_sampled;

  ntm_inverter_top #(.DATA_SIZE(DATA_SIZE)) uut (
    .CLK(CLK), .RST(RST),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .done(done)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Watchdog
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
      $display("Test failures found");
      $fatal(1, "Timeout");
    end
  end

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic report_mismatch(input string name, input logic [DATA_SIZE-1:0] got,
                                 input logic [DATA_SIZE-1:0] expected);
    $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
    $display("Test failures found");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_error(input string msg);
    $display("Error: %s", msg);
    $display("Test failures found");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [DATA_SIZE-1:0] got,
                             input logic [DATA_SIZE-1:0] expected);
    assert (got == expected) else report_mismatch(name, got, expected);
  endtask

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int count, output int value);
    value = 0;
    for (int b = 0; b < count; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      value  = (value << 1) | int'(lfsr_q[0]);
    end
  endtask

  function automatic logic [11:0] window_addr(input int word);
    return ntm_pkg::WINDOW_BASE + 12'(word * 4);
  endfunction

  // Row-major element k onto the fixed RAM pitch
  function automatic int elem_word(input int k, input int size_j);
    return (k / size_j) * ntm_pkg::MAX_COLS + (k % size_j);
  endfunction

  // Guard pattern unique to each word
  function automatic logic [DATA_SIZE-1:0] guard_value(input int word);
    logic [5:0] a;
    a = word[5:0];
    return {4'hA, a, ~a};
  endfunction

  //////////////////////////////
  // APB master
  //////////////////////////////

  task automatic apb_transfer(input logic write, input logic [11:0] addr,
                              input logic [DATA_SIZE-1:0] wdata,
                              output logic [DATA_SIZE-1:0] rdata, output logic err);
    // Setup phase
    @(posedge CLK);
    #5;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    // Access phase held until pready
    @(posedge CLK);
    #5;
    penable = 1'b1;
    @(negedge CLK);
    while (!pready) begin
      @(negedge CLK);
    end
    rdata        = prdata;
    err          = pslverr;
    done_sampled = done;
    @(posedge CLK);
    #5;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [DATA_SIZE-1:0] wdata,
                           output logic err);
    logic [DATA_SIZE-1:0] ignored;
    apb_transfer(1'b1, addr, wdata, ignored, err);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [DATA_SIZE-1:0] rdata,
                          output logic err);
    apb_transfer(1'b0, addr, '0, rdata, err);
  endtask

  //////////////////////////////
  // Stimulus file
  //////////////////////////////

  task automatic read_stim();
    int                m;
    int                si;
    int                sj;
    int                ni;
    int                er;
    int                fd;
    int                count;
    int                value;
    logic [8*128-1:0]  header;
    fd = $fopen("dv/inverter_stim.txt", "r");
    assert (fd != 0) else report_error("cannot open dv/inverter_stim.txt");
    // Two column description lines
    count = $fgets(header, fd);
    count = $fgets(header, fd);
    while ($fscanf(fd, "%h %h %h %h %h", m, si, sj, ni, er) == 5) begin
      case_mod.push_back(m);
      case_size_i.push_back(si);
      case_size_j.push_back(sj);
      case_no_inv.push_back(ni);
      case_err.push_back(er);
      if (er == 0) begin
        for (int k = 0; k < 2 * si * sj; k++) begin
          count = $fscanf(fd, "%h", value);
          assert (count == 1) else report_error("stim file ends inside a case");
          if (k < si * sj) begin
            elem_q.push_back(value);
          end else begin
            expect_q.push_back(value);
          end
        end
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////
  // Test sequences
  //////////////////////////////

  // Accesses refused while the engine runs
  // The window write targets the last element, still unread by the engine
  task automatic probe_busy(input int m, input int last_word);
    logic [DATA_SIZE-1:0] rd;
    logic                 err;
    apb_write(window_addr(last_word), 16'hDEAD, err);
    check_value("pslverr window write while busy", 16'(err), 16'h1);
    apb_read(window_addr(1), rd, err);
    check_value("pslverr window read while busy", 16'(err), 16'h1);
    apb_write(ntm_pkg::REG_MODULO, 16'(m + 2), err);
    check_value("pslverr MODULO write while busy", 16'(err), 16'h1);
    apb_write(ntm_pkg::REG_SIZE_J, 16'h1, err);
    check_value("pslverr SIZE_J write while busy", 16'(err), 16'h1);
    apb_write(ntm_pkg::REG_CTRL, 16'h1, err);
    check_value("pslverr start while busy", 16'(err), 16'h1);
  endtask

  task automatic run_case(input int c);
    int                   m;
    int                   si;
    int                   sj;
    int                   n;
    int                   nbits;
    int                   idle;
    int                   guards[$];
    longint               prod;
    logic [DATA_SIZE-1:0] rd;
    logic                 err;
    m  = case_mod[c];
    si = case_size_i[c];
    sj = case_size_j[c];
    n  = (case_err[c] == 0) ? si * sj : 0;
    apb_write(ntm_pkg::REG_MODULO, 16'(m), err);
    check_value("pslverr MODULO write", 16'(err), 16'h0);
    apb_write(ntm_pkg::REG_SIZE_I, 16'(si), err);
    check_value("pslverr SIZE_I write", 16'(err), 16'h0);
    apb_write(ntm_pkg::REG_SIZE_J, 16'(sj), err);
    check_value("pslverr SIZE_J write", 16'(err), 16'h0);
    if (n > 0) begin
      // Column right of the matrix and the row below it
      if (sj < ntm_pkg::MAX_COLS) begin
        for (int r = 0; r < si; r++) guards.push_back(r * ntm_pkg::MAX_COLS + sj);
      end
      if (si < ntm_pkg::MAX_COLS) begin
        for (int col = 0; col < ntm_pkg::MAX_COLS; col++) begin
          guards.push_back(si * ntm_pkg::MAX_COLS + col);
        end
      end
      foreach (guards[g]) begin
        apb_write(window_addr(guards[g]), guard_value(guards[g]), err);
        check_value("pslverr guard write", 16'(err), 16'h0);
      end
      for (int k = 0; k < n; k++) begin
        apb_write(window_addr(elem_word(k, sj)), 16'(elem_q[elem_base + k]), err);
        check_value("pslverr element write", 16'(err), 16'h0);
      end
      // Readback before start
      for (int k = 0; k < n; k++) begin
        apb_read(window_addr(elem_word(k, sj)), rd, err);
        check_value($sformatf("prdata element %0d before start", k), rd,
                    16'(elem_q[elem_base + k]));
        check_value("pslverr element read", 16'(err), 16'h0);
      end
    end
    apb_write(ntm_pkg::REG_CTRL, 16'h1, err);
    check_value("pslverr start", 16'(err), 16'(case_err[c]));
    if (case_err[c] != 0) begin
      apb_read(ntm_pkg::REG_STATUS, rd, err);
      check_value("STATUS busy after refused start", 16'(rd[0]), 16'h0);
    end else begin
      // Four or more elements keep the engine busy through the probes
      if (n >= 4) probe_busy(m, elem_word(n - 1, sj));
      rd = '0;
      while (!rd[1]) begin
        take_bits(1, nbits);
        take_bits(nbits + 1, idle);
        repeat (idle) @(posedge CLK);
        apb_read(ntm_pkg::REG_STATUS, rd, err);
        assert (rd[0] != rd[1]) else report_error("STATUS busy and done agree while polling");
        check_value("done", 16'(done_sampled), 16'(rd[1]));
      end
      check_value("STATUS no_inverse", 16'(rd[2]), 16'(case_no_inv[c]));
      for (int k = 0; k < n; k++) begin
        apb_read(window_addr(elem_word(k, sj)), rd, err);
        check_value($sformatf("prdata result %0d", k), rd, 16'(expect_q[elem_base + k]));
        if (expect_q[elem_base + k] != 0) begin
          prod = (longint'(elem_q[elem_base + k]) * longint'(rd)) % longint'(m);
          assert (prod == 1)
            else report_error($sformatf("result %0d times its element is not 1 mod 0x%0h", k, m));
        end
      end
      foreach (guards[g]) begin
        apb_read(window_addr(guards[g]), rd, err);
        check_value($sformatf("prdata guard word %0d", guards[g]), rd, guard_value(guards[g]));
      end
      apb_read(ntm_pkg::REG_MODULO, rd, err);
      check_value("MODULO after run", rd, 16'(m));
    end
    elem_base += n;
  endtask

  initial begin
    RST     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    read_stim();
    cycle_limit = elem_q.size() * ELEM_CYCLES + 2000;
    repeat (4) @(posedge CLK);
    #5;
    RST = 1'b0;
    for (int c = 0; c < case_mod.size(); c++) run_case(c);
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== dv/inverter_stim.txt ====
# modulus size_i size_j no_inverse start_err (hex), then the elements row by row
# and the expected inverses; a refused start (start_err 1) has neither
d 2 2 0 0
1 2 3 4
1 7 9 a
f 3 5 1 0
1 2 3 4 5 7 8 0 b d e a 10 11 6
1 8 0 4 0 d 2 0 b 7 e 0 1 8 0
61 2 3 0 0
2 3 5 a 60 32
31 41 27 44 60 21
10 2 2 0 1
d 0 3 0 1
d 9 2 0 1
d 1 9 0 1
1 1 1 0 1
fff1 2 2 0 0
2 fff0 3 ffff
7ff9 fff0 aaa1 eda9
b 1 8 0 0
1 2 3 4 5 6 7 8
1 6 4 3 9 2 8 7
b 8 1 1 0
9 a 0 b 1 2 3 4
5 a 0 0 1 6 4 3

// ==== build.f ====
common/ntm_pkg.sv
common/ntm_mem_if.sv
verilog/ntm_matrix_ram.sv
verilog/ntm_mem_arbiter.sv
verilog/ntm_apb_regs.sv
matrix_inverter/ntm_scalar_inverter.sv
matrix_inverter/ntm_matrix_inverter.sv
verilog/ntm_inverter_top.sv
dv/ntm_inverter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the matrix inverter testbench with Verilator, log in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module ntm_inverter_tb -f build.f -o ntm_inverter_sim \
  && ./obj_dir/ntm_inverter_sim > sim.log 2>&1
cat sim.log 2>/dev/null
! grep -q "Test failures found" sim.log && grep -q "All tests passed!" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
